// ==== verilog/mmc3_pkg.sv ====
/* Constants and register opcodes shared by all MMC3 blocks.
   Output addresses assume a 22-bit cartridge memory space split into PRG ROM, PRG RAM and CHR. */
package mmc3_pkg;

	// Bus widths
	localparam int OUT_ADDR_W = 22; // Cartridge memory address
	localparam int CPU_ADDR_W = 16; // CPU A15..A0
	localparam int PPU_ADDR_W = 14; // PPU A13..A0

	// Bank register widths
	localparam int PRG_BANK_W = 6; // 8 KB PRG page, up to 512 KB
	localparam int CHR_BANK_W = 8; // 1 KB CHR page, up to 256 KB

	// Fixed PRG pages, the last two of a full 512 KB ROM
	localparam logic [PRG_BANK_W-1:0] PRG_FIXED_LAST   = 6'd63; // Always at $E000
	localparam logic [PRG_BANK_W-1:0] PRG_FIXED_SECOND = 6'd62; // $C000 or $8000 by mode

	// Region bases placed above the page and offset bits
	localparam logic [2:0] PRG_ROM_BASE = 3'b000;         // PRG ROM at 0
	localparam logic [8:0] PRG_RAM_BASE = 9'b1_1110_0000; // 8 KB PRG RAM window
	localparam logic [2:0] CHR_ROM_BASE = 3'b100;         // CHR after PRG

	// Register targets, encoded as {A14, A13, A0} of a write to $8000-$FFFF
	typedef enum logic [2:0] {
		OP_BANK_SEL   = 3'b000, // $8000 even
		OP_BANK_DATA  = 3'b001, // $8001 odd
		OP_MIRROR     = 3'b010, // $A000 even
		OP_RAM_PROT   = 3'b011, // $A001 odd
		OP_IRQ_LATCH  = 3'b100, // $C000 even
		OP_IRQ_RELOAD = 3'b101, // $C001 odd
		OP_IRQ_DIS    = 3'b110, // $E000 even
		OP_IRQ_EN     = 3'b111  // $E001 odd
	} mmc3_reg_op_t;

	// The four IRQ opcodes share A14 high and A13 high/low, so
	// bit 2 of the opcode marks every write meant for the IRQ block.
	// Mapping registers only see opcodes with bit 2 low.

endpackage

// ==== verilog/mmc3_reg_file.sv ====
/* CPU write decoder and mapping registers. A write is taken when ce_i, cpu_wr_i and A15 are high.
   IRQ register writes are only decoded here and passed on as opcode and strobe. */
`timescale 1ns/10ps

module mmc3_reg_file
	import mmc3_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  ce_i,          // CPU clock enable
	input  logic                  cpu_wr_i,
	input  logic [CPU_ADDR_W-1:0] cpu_addr_i,
	input  logic [7:0]            cpu_data_i,
	output logic [PRG_BANK_W-1:0] prg_bank_0_o,  // R6
	output logic [PRG_BANK_W-1:0] prg_bank_1_o,  // R7
	output logic                  prg_mode_o,    // Swaps $8000 and $C000
	output logic [CHR_BANK_W-1:0] chr_bank_0_o,  // R0, 2 KB page
	output logic [CHR_BANK_W-1:0] chr_bank_1_o,  // R1, 2 KB page
	output logic [CHR_BANK_W-1:0] chr_bank_2_o,  // R2
	output logic [CHR_BANK_W-1:0] chr_bank_3_o,  // R3
	output logic [CHR_BANK_W-1:0] chr_bank_4_o,  // R4
	output logic [CHR_BANK_W-1:0] chr_bank_5_o,  // R5
	output logic                  chr_invert_o,  // A12 inversion
	output logic                  mirror_h_o,    // 1 = horizontal
	output logic                  ram_enable_o,
	output logic                  ram_protect_o,
	output logic                  irq_wr_o,      // One-cycle write strobe
	output mmc3_reg_op_t          reg_op_o
);

	logic       wr_en;    // Qualified register write
	logic [2:0] bank_sel; // Target of the next bank data write

	// Register decode
	assign wr_en    = ce_i && cpu_wr_i && cpu_addr_i[15];
	assign reg_op_o = mmc3_reg_op_t'({cpu_addr_i[14:13], cpu_addr_i[0]});
	assign irq_wr_o = wr_en; // IRQ block picks its own opcodes

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bank_sel      <= 3'd0;
			prg_mode_o    <= 1'b0;
			chr_invert_o  <= 1'b0;
			prg_bank_0_o  <= '0;
			prg_bank_1_o  <= '0;
			chr_bank_0_o  <= '0;
			chr_bank_1_o  <= '0;
			chr_bank_2_o  <= '0;
			chr_bank_3_o  <= '0;
			chr_bank_4_o  <= '0;
			chr_bank_5_o  <= '0;
			mirror_h_o    <= 1'b0; // Vertical out of reset
			ram_enable_o  <= 1'b0;
			ram_protect_o <= 1'b0;
		end else if (wr_en) begin
			case (reg_op_o)
				OP_BANK_SEL: begin
					chr_invert_o <= cpu_data_i[7];
					prg_mode_o   <= cpu_data_i[6];
					bank_sel     <= cpu_data_i[2:0];
				end
				OP_BANK_DATA: begin
					case (bank_sel)
						3'd0: chr_bank_0_o <= {1'b0, cpu_data_i[7:1]}; // 2 KB granularity
						3'd1: chr_bank_1_o <= {1'b0, cpu_data_i[7:1]};
						3'd2: chr_bank_2_o <= cpu_data_i;
						3'd3: chr_bank_3_o <= cpu_data_i;
						3'd4: chr_bank_4_o <= cpu_data_i;
						3'd5: chr_bank_5_o <= cpu_data_i;
						3'd6: prg_bank_0_o <= cpu_data_i[PRG_BANK_W-1:0]; // Upper bits dropped
						default: prg_bank_1_o <= cpu_data_i[PRG_BANK_W-1:0]; // R7
					endcase
				end
				OP_MIRROR: mirror_h_o <= cpu_data_i[0];
				OP_RAM_PROT: begin
					ram_enable_o  <= cpu_data_i[7];
					ram_protect_o <= cpu_data_i[6]; // Write protect only
				end
				default: ; // IRQ registers live in the IRQ block
			endcase
		end
	end

endmodule

// ==== verilog/mmc3_prg_map.sv ====
/* CPU address to PRG memory mapping, purely combinational.
   PRG RAM is a single 8 KB window at $6000-$7FFF; ROM writes are never allowed. */
`timescale 1ns/10ps

module mmc3_prg_map
	import mmc3_pkg::*;
(
	input  logic [CPU_ADDR_W-1:0] cpu_addr_i,
	input  logic                  cpu_wr_i,
	input  logic [PRG_BANK_W-1:0] prg_bank_0_i,  // R6
	input  logic [PRG_BANK_W-1:0] prg_bank_1_i,  // R7
	input  logic                  prg_mode_i,
	input  logic                  ram_enable_i,
	input  logic                  ram_protect_i,
	output logic [OUT_ADDR_W-1:0] prg_addr_o,
	output logic                  prg_allow_o
);

	logic [PRG_BANK_W-1:0] prg_page; // Selected 8 KB page
	logic                  ram_win;  // $6000-$7FFF
	logic                  ram_hit;  // RAM access granted
	logic                  rom_rd;   // ROM read at $8000 and up

	// Page select by slot A14:A13 and mode
	always_comb begin
		case (cpu_addr_i[14:13])
			2'b00: prg_page = prg_mode_i ? PRG_FIXED_SECOND : prg_bank_0_i; // $8000
			2'b01: prg_page = prg_bank_1_i;                                 // $A000
			2'b10: prg_page = prg_mode_i ? prg_bank_0_i : PRG_FIXED_SECOND; // $C000
			default: prg_page = PRG_FIXED_LAST;                             // $E000
		endcase
	end

	assign ram_win = (cpu_addr_i[15:13] == 3'b011);
	assign ram_hit = ram_win && ram_enable_i && !(ram_protect_i && cpu_wr_i);
	assign rom_rd  = cpu_addr_i[15] && !cpu_wr_i;

	// RAM window overrides the ROM address
	always_comb begin
		if (ram_hit)
			prg_addr_o = {PRG_RAM_BASE, cpu_addr_i[12:0]};
		else
			prg_addr_o = {PRG_ROM_BASE, prg_page, cpu_addr_i[12:0]};
	end

	assign prg_allow_o = rom_rd || ram_hit;

endmodule

// ==== verilog/mmc3_chr_map.sv ====
/* PPU address to CHR memory mapping and nametable control, purely combinational.
   Only two-screen mirroring is supported; vram_ce_o selects console VRAM for $2000 and up. */
`timescale 1ns/10ps

module mmc3_chr_map
	import mmc3_pkg::*;
(
	input  logic [PPU_ADDR_W-1:0] ppu_addr_i,
	input  logic [CHR_BANK_W-1:0] chr_bank_0_i,  // R0, 2 KB page
	input  logic [CHR_BANK_W-1:0] chr_bank_1_i,  // R1, 2 KB page
	input  logic [CHR_BANK_W-1:0] chr_bank_2_i,
	input  logic [CHR_BANK_W-1:0] chr_bank_3_i,
	input  logic [CHR_BANK_W-1:0] chr_bank_4_i,
	input  logic [CHR_BANK_W-1:0] chr_bank_5_i,
	input  logic                  chr_invert_i,
	input  logic                  mirror_h_i,
	input  logic                  chr_ram_i,     // Board has CHR RAM
	output logic [OUT_ADDR_W-1:0] chr_addr_o,
	output logic                  chr_allow_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o
);

	logic                half_hi;  // Pattern half after inversion
	logic [CHR_BANK_W:0] chr_page; // 1 KB page number

	assign half_hi = ppu_addr_i[12] ^ chr_invert_i;

	always_comb begin
		if (!half_hi) begin
			// 2 KB pages, A10 picks the 1 KB half
			if (ppu_addr_i[11])
				chr_page = {chr_bank_1_i, ppu_addr_i[10]};
			else
				chr_page = {chr_bank_0_i, ppu_addr_i[10]};
		end else begin
			case (ppu_addr_i[11:10])
				2'b00: chr_page = {1'b0, chr_bank_2_i};
				2'b01: chr_page = {1'b0, chr_bank_3_i};
				2'b10: chr_page = {1'b0, chr_bank_4_i};
				default: chr_page = {1'b0, chr_bank_5_i};
			endcase
		end
	end

	assign chr_addr_o  = {CHR_ROM_BASE, chr_page, ppu_addr_i[9:0]};
	assign chr_allow_o = chr_ram_i;                                   // Writes only to RAM
	assign vram_a10_o  = mirror_h_i ? ppu_addr_i[11] : ppu_addr_i[10]; // H uses A11
	assign vram_ce_o   = ppu_addr_i[13];                              // Nametable space

endmodule

// ==== verilog/mmc3_scanline_irq.sv ====
/* Scanline counter clocked by filtered rising edges of PPU A12.
   A12 must stay low for A12_LOW_CYCLES enabled cycles before another rise counts. */
`timescale 1ns/10ps

module mmc3_scanline_irq
	import mmc3_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 16,   // Low time before a rise counts
	parameter bit OLD_IRQ_MODE   = 1'b0  // Alternate revision
) (
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         ce_i,
	input  logic         ppu_a12_i,
	input  logic         irq_wr_i,
	input  mmc3_reg_op_t reg_op_i,
	input  logic [7:0]   cpu_data_i,
	output logic         irq_o
);

	localparam int FILT_W = (A12_LOW_CYCLES > 1) ? $clog2(A12_LOW_CYCLES) : 1;
	localparam logic [FILT_W-1:0] FILT_LOAD = FILT_W'(A12_LOW_CYCLES - 1);

	logic [FILT_W-1:0] filt_cnt;    // Low-time filter
	logic [7:0]        irq_latch;   // Reload value
	logic [7:0]        irq_count;   // Scanline counter
	logic [7:0]        next_count;
	logic              reload_pend; // Reload on next clock
	logic              irq_en;
	logic              cnt_clk;     // Qualified A12 rise
	logic              irq_set;

	assign cnt_clk    = ce_i && ppu_a12_i && (filt_cnt == '0);
	assign next_count = (irq_count == 8'd0 || reload_pend) ? irq_latch : irq_count - 8'd1;
	// Old revision fires only on a decrement to zero or a reload of zero
	assign irq_set = (next_count == 8'd0) && irq_en &&
		(!OLD_IRQ_MODE || irq_count != 8'd0 || reload_pend);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			filt_cnt    <= '0;
			irq_latch   <= 8'd0;
			irq_count   <= 8'd0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			if (ce_i) begin
				if (ppu_a12_i)
					filt_cnt <= FILT_LOAD; // Rearm while A12 high
				else if (filt_cnt != '0)
					filt_cnt <= filt_cnt - 1'b1;
			end
			if (cnt_clk) begin
				irq_count   <= next_count;
				reload_pend <= 1'b0;
				if (irq_set)
					irq_o <= 1'b1; // Held until disabled
			end
			// CPU writes after the counter so they win on the same edge
			if (irq_wr_i) begin
				case (reg_op_i)
					OP_IRQ_LATCH: irq_latch <= cpu_data_i;
					OP_IRQ_RELOAD: reload_pend <= 1'b1;
					OP_IRQ_DIS: begin
						irq_en <= 1'b0;
						irq_o  <= 1'b0; // Also acknowledges
					end
					OP_IRQ_EN: irq_en <= 1'b1;
					default: ; // Mapping registers
				endcase
			end
		end
	end

endmodule

// ==== verilog/mmc3_mapper.sv ====
/* MMC3 mapper top, iNES mapper 4. Writes are taken on clk edges with ce_i and cpu_wr_i high.
   Mapping outputs are combinational from the address inputs; there is no back-pressure. */
`timescale 1ns/10ps

module mmc3_mapper
	import mmc3_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 16,
	parameter bit OLD_IRQ_MODE   = 1'b0
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  ce_i,        // CPU clock enable
	input  logic [CPU_ADDR_W-1:0] cpu_addr_i,
	input  logic [7:0]            cpu_data_i,
	input  logic                  cpu_wr_i,
	input  logic [PPU_ADDR_W-1:0] ppu_addr_i,
	input  logic                  chr_ram_i,   // Board fitted with CHR RAM
	output logic [OUT_ADDR_W-1:0] prg_addr_o,
	output logic                  prg_allow_o,
	output logic [OUT_ADDR_W-1:0] chr_addr_o,
	output logic                  chr_allow_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o,
	output logic                  irq_o
);

	logic [PRG_BANK_W-1:0] prg_bank_0, prg_bank_1;
	logic [CHR_BANK_W-1:0] chr_bank_0, chr_bank_1, chr_bank_2;
	logic [CHR_BANK_W-1:0] chr_bank_3, chr_bank_4, chr_bank_5;
	logic                  prg_mode, chr_invert, mirror_h;
	logic                  ram_enable, ram_protect;
	logic                  irq_wr;
	mmc3_reg_op_t          reg_op;

	mmc3_reg_file i_reg_file (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .cpu_wr_i(cpu_wr_i),
		.cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i),
		.prg_bank_0_o(prg_bank_0), .prg_bank_1_o(prg_bank_1), .prg_mode_o(prg_mode),
		.chr_bank_0_o(chr_bank_0), .chr_bank_1_o(chr_bank_1), .chr_bank_2_o(chr_bank_2),
		.chr_bank_3_o(chr_bank_3), .chr_bank_4_o(chr_bank_4), .chr_bank_5_o(chr_bank_5),
		.chr_invert_o(chr_invert), .mirror_h_o(mirror_h),
		.ram_enable_o(ram_enable), .ram_protect_o(ram_protect),
		.irq_wr_o(irq_wr), .reg_op_o(reg_op)
	);

	mmc3_prg_map i_prg_map (
		.cpu_addr_i(cpu_addr_i), .cpu_wr_i(cpu_wr_i),
		.prg_bank_0_i(prg_bank_0), .prg_bank_1_i(prg_bank_1), .prg_mode_i(prg_mode),
		.ram_enable_i(ram_enable), .ram_protect_i(ram_protect),
		.prg_addr_o(prg_addr_o), .prg_allow_o(prg_allow_o)
	);

	mmc3_chr_map i_chr_map (
		.ppu_addr_i(ppu_addr_i),
		.chr_bank_0_i(chr_bank_0), .chr_bank_1_i(chr_bank_1), .chr_bank_2_i(chr_bank_2),
		.chr_bank_3_i(chr_bank_3), .chr_bank_4_i(chr_bank_4), .chr_bank_5_i(chr_bank_5),
		.chr_invert_i(chr_invert), .mirror_h_i(mirror_h), .chr_ram_i(chr_ram_i),
		.chr_addr_o(chr_addr_o), .chr_allow_o(chr_allow_o),
		.vram_a10_o(vram_a10_o), .vram_ce_o(vram_ce_o)
	);

	// Counter watches raw PPU A12, before any CHR inversion
	mmc3_scanline_irq #(
		.A12_LOW_CYCLES(A12_LOW_CYCLES),
		.OLD_IRQ_MODE(OLD_IRQ_MODE)
	) i_scanline_irq (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i), .ppu_a12_i(ppu_addr_i[12]),
		.irq_wr_i(irq_wr), .reg_op_i(reg_op), .cpu_data_i(cpu_data_i), .irq_o(irq_o)
	);

endmodule

// ==== tests/mmc3_tb.sv ====
/* Directed testbench for the MMC3 mapper with default parameters.
   Inputs change 1 ns after a rising clk edge; outputs are sampled 2 ns later in the same cycle. */
`timescale 1ns/10ps

module mmc3_tb;

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        ce_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_data_i;
	logic        cpu_wr_i;
	logic [13:0] ppu_addr_i;
	logic        chr_ram_i;
	logic [21:0] prg_addr_o;
	logic        prg_allow_o;
	logic [21:0] chr_addr_o;
	logic        chr_allow_o;
	logic        vram_a10_o;
	logic        vram_ce_o;
	logic        irq_o;

	int unsigned lcg_state = 94571; // Fixed seed
	int          err_cnt   = 0;
	int          tmo_cnt   = 0;
	logic [7:0]  chr_val [6];       // Values written to R0-R5

	mmc3_mapper i_mmc3_mapper (
		.clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i),
		.cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i), .cpu_wr_i(cpu_wr_i),
		.ppu_addr_i(ppu_addr_i), .chr_ram_i(chr_ram_i),
		.prg_addr_o(prg_addr_o), .prg_allow_o(prg_allow_o),
		.chr_addr_o(chr_addr_o), .chr_allow_o(chr_allow_o),
		.vram_a10_o(vram_a10_o), .vram_ce_o(vram_ce_o), .irq_o(irq_o)
	);

	always #4 clk = ~clk; // 8 ns period

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15]; // Upper bits spread better
	endfunction

	// Expected 8 KB page for a PRG slot
	function automatic logic [5:0] prg_page_exp(input logic mode, input logic [1:0] slot,
		input logic [5:0] r6, input logic [5:0] r7);
		case (slot)
			2'd0: return mode ? 6'd62 : r6;
			2'd1: return r7;
			2'd2: return mode ? r6 : 6'd62;
			default: return 6'd63;
		endcase
	endfunction

	task automatic report_error(input string test, input logic [31:0] exp, input logic [31:0] act);
		err_cnt++;
		$display("error %s: expected %0h, actual %0h", test, exp, act);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		cpu_wr_i = 1'b0;
		ce_i     = 1'b1;
		repeat (n) next_cycle();
	endtask

	// One enabled write cycle or a blocked one when ce is low
	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data, input logic ce);
		next_cycle();
		cpu_addr_i = addr;
		cpu_data_i = data;
		cpu_wr_i   = 1'b1;
		ce_i       = ce;
		next_cycle();
		cpu_wr_i = 1'b0;
		ce_i     = 1'b1;
	endtask

	// CPU access for mapping checks with ce low on writes so no register changes
	task automatic probe_cpu(input logic [15:0] addr, input logic wr);
		next_cycle();
		cpu_addr_i = addr;
		cpu_wr_i   = wr;
		ce_i       = !wr;
		#2;
	endtask

	task automatic probe_ppu(input logic [13:0] addr);
		next_cycle();
		ppu_addr_i = addr;
		#2;
	endtask

	// One cycle of A12 high followed by low_cycles low cycles
	task automatic a12_pulse(input int low_cycles);
		next_cycle();
		ppu_addr_i = 14'h1000;
		next_cycle();
		ppu_addr_i = 14'h0000;
		repeat (low_cycles) next_cycle();
	endtask

	task automatic wait_irq(input int max_cycles);
		int n;
		n = 0;
		while (irq_o !== 1'b1 && n < max_cycles) begin
			next_cycle();
			n++;
		end
		if (irq_o !== 1'b1) begin
			tmo_cnt++;
			$display("timeout: irq_o did not rise within %0d cycles", max_cycles);
		end
	endtask

	task automatic check_prg_slots(input string test, input logic mode,
		input logic [5:0] r6, input logic [5:0] r7);
		logic [15:0] r;
		logic [21:0] exp;
		for (int s = 0; s < 4; s++) begin
			r = lcg_next();
			probe_cpu({1'b1, 2'(s), r[12:0]}, 1'b0);
			exp = {3'b000, prg_page_exp(mode, 2'(s), r6, r7), r[12:0]};
			if (prg_addr_o !== exp) report_error(test, exp, prg_addr_o);
			if (prg_allow_o !== 1'b1) report_error(test, 1, prg_allow_o);
		end
	endtask

	task automatic check_chr_pages(input logic inv);
		logic [15:0] r;
		logic [13:0] a;
		logic [7:0]  v;
		logic [8:0]  page;
		logic [21:0] exp;
		for (int k = 0; k < 10; k++) begin
			r = lcg_next();
			a = r[13:0];
			if (k < 2)
				a = {1'b0, inv, 1'b0, k[0], 10'h155}; // Low half with A10 both ways
			probe_ppu(a);
			if ((a[12] ^ inv) == 1'b0) begin
				v    = a[11] ? chr_val[1] : chr_val[0];
				page = {1'b0, v[7:1], a[10]}; // Bit 0 replaced by A10
			end else begin
				page = {1'b0, chr_val[2 + int'(a[11:10])]};
			end
			exp = {3'b100, page, a[9:0]};
			if (chr_addr_o !== exp) report_error("chr_banking", exp, chr_addr_o);
		end
	endtask

	task automatic reset_and_fixed_pages();
		logic [15:0] r;
		logic [21:0] exp;
		r = lcg_next();
		probe_cpu({3'b111, r[12:0]}, 1'b0);
		exp = {3'b000, 6'd63, r[12:0]};
		if (prg_addr_o !== exp) report_error("reset_fixed", exp, prg_addr_o);
		probe_cpu(16'hFFFF, 1'b0);
		exp = {3'b000, 6'd63, 13'h1FFF};
		if (prg_addr_o !== exp) report_error("reset_fixed", exp, prg_addr_o);
		probe_cpu({3'b110, r[12:0]}, 1'b0);
		exp = {3'b000, 6'd62, r[12:0]};
		if (prg_addr_o !== exp) report_error("reset_fixed", exp, prg_addr_o);
		probe_cpu(16'h8000, 1'b0);
		if (prg_allow_o !== 1'b1) report_error("reset_fixed", 1, prg_allow_o);
		probe_cpu(16'h8000, 1'b1); // ROM never writable
		if (prg_allow_o !== 1'b0) report_error("reset_fixed", 0, prg_allow_o);
		probe_cpu(16'h6000, 1'b0); // RAM still disabled
		if (prg_allow_o !== 1'b0) report_error("reset_fixed", 0, prg_allow_o);
		if (irq_o !== 1'b0) report_error("reset_fixed", 0, irq_o);
	endtask

	task automatic prg_banking();
		logic [15:0] r;
		logic [5:0]  v6;
		logic [5:0]  v7;
		r  = lcg_next();
		v6 = r[5:0];
		r  = lcg_next();
		v7 = r[5:0];
		write_reg(16'h8000, 8'h06, 1'b1); // Select R6
		write_reg(16'h8001, {2'b11, v6}, 1'b1); // Upper bits ignored
		write_reg(16'h8000, 8'h07, 1'b1);
		write_reg(16'h8001, {2'b00, v7}, 1'b1);
		check_prg_slots("prg_mode0", 1'b0, v6, v7);
		write_reg(16'h8000, 8'h47, 1'b1); // Mode 1 with R7 still selected
		check_prg_slots("prg_mode1", 1'b1, v6, v7);
		write_reg(16'h8001, {2'b00, ~v7}, 1'b0); // Blocked by ce low
		check_prg_slots("prg_ce_low", 1'b1, v6, v7);
		write_reg(16'h8000, 8'h00, 1'b1);
	endtask

	task automatic chr_banking();
		logic [15:0] r;
		for (int i = 0; i < 6; i++) begin
			r = lcg_next();
			chr_val[i] = r[7:0];
			write_reg(16'h8000, 8'(i), 1'b1);
			write_reg(16'h8001, chr_val[i], 1'b1);
		end
		check_chr_pages(1'b0);
		write_reg(16'h8000, 8'h80, 1'b1); // Invert A12
		check_chr_pages(1'b1);
		write_reg(16'h8000, 8'h00, 1'b1);
		chr_ram_i = 1'b0;
		#2;
		if (chr_allow_o !== 1'b0) report_error("chr_allow", 0, chr_allow_o);
		next_cycle();
		chr_ram_i = 1'b1;
		#2;
		if (chr_allow_o !== 1'b1) report_error("chr_allow", 1, chr_allow_o);
	endtask

	task automatic mirroring_and_ram();
		logic [15:0] r;
		logic [13:0] a;
		logic        exp_a10;
		logic [21:0] exp;
		for (int m = 0; m < 2; m++) begin
			write_reg(16'hA000, 8'(m), 1'b1);
			for (int k = 0; k < 4; k++) begin
				r = lcg_next();
				a = r[13:0];
				probe_ppu(a);
				exp_a10 = (m == 1) ? a[11] : a[10]; // Horizontal follows A11
				if (vram_a10_o !== exp_a10) report_error("mirroring", exp_a10, vram_a10_o);
				if (vram_ce_o !== a[13]) report_error("vram_ce", a[13], vram_ce_o);
			end
		end
		r = lcg_next();
		exp = {9'h1E0, r[12:0]};
		write_reg(16'hA001, 8'h80, 1'b1); // Enable without protect
		for (int w = 0; w < 2; w++) begin
			probe_cpu({3'b011, r[12:0]}, w[0]);
			if (prg_addr_o !== exp) report_error("prg_ram", exp, prg_addr_o);
			if (prg_allow_o !== 1'b1) report_error("prg_ram", 1, prg_allow_o);
		end
		write_reg(16'hA001, 8'hC0, 1'b1); // Enable and protect
		probe_cpu({3'b011, r[12:0]}, 1'b1);
		if (prg_allow_o !== 1'b0) report_error("prg_ram_prot", 0, prg_allow_o);
		probe_cpu({3'b011, r[12:0]}, 1'b0);
		if (prg_addr_o !== exp) report_error("prg_ram_prot", exp, prg_addr_o);
		if (prg_allow_o !== 1'b1) report_error("prg_ram_prot", 1, prg_allow_o);
		write_reg(16'hA001, 8'h00, 1'b1);
	endtask

	task automatic scanline_irq();
		logic [15:0] r;
		int          n;
		ppu_addr_i = 14'h0000;
		idle(20); // Let the A12 filter run out
		r = lcg_next();
		n = int'(r[2:0]) + 1;
		write_reg(16'hC000, 8'(n), 1'b1); // Latch
		write_reg(16'hC001, 8'h00, 1'b1); // Reload request
		write_reg(16'hE001, 8'h00, 1'b1); // Enable
		for (int k = 1; k <= n; k++) begin
			a12_pulse((k == n) ? 3 : 20); // Short gap after the last one
			if (irq_o !== 1'b0) report_error("irq_count", 0, irq_o);
		end
		a12_pulse(20); // Follows only 3 low cycles and is filtered out
		if (irq_o !== 1'b0) report_error("irq_filter", 0, irq_o);
		next_cycle();
		ppu_addr_i = 14'h1000; // Pulse N+1
		wait_irq(4);
		ppu_addr_i = 14'h0000;
		if (irq_o !== 1'b1) report_error("irq_fire", 1, irq_o);
		write_reg(16'hE000, 8'h00, 1'b1); // Disable and acknowledge
		if (irq_o !== 1'b0) report_error("irq_disable", 0, irq_o);
	endtask

	initial begin
		rst_n_i    = 1'b0;
		ce_i       = 1'b1;
		cpu_addr_i = 16'h0000;
		cpu_data_i = 8'h00;
		cpu_wr_i   = 1'b0;
		ppu_addr_i = 14'h0000;
		chr_ram_i  = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		reset_and_fixed_pages();
		prg_banking();
		chr_banking();
		mirroring_and_ram();
		scanline_irq();
		$display("errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/mmc3_pkg.sv
verilog/mmc3_reg_file.sv
verilog/mmc3_prg_map.sv
verilog/mmc3_chr_map.sv
verilog/mmc3_scanline_irq.sv
verilog/mmc3_mapper.sv
tests/mmc3_tb.sv

// ==== Makefile ====
# Verilator build and run of the MMC3 mapper testbench
TOP = mmc3_tb

all: run

run:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -qx "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module mmc3_mapper

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
